// File: design/axil_adapter.sv
`timescale 1ns/10ps

module axil_adapter
  import regblk_pkg::*;
#(
  parameter int ADDR_W      = regblk_pkg::ADDR_W,
  parameter int DATA_W      = regblk_pkg::DATA_W,
  parameter bit WRITE_FIRST = 1'b1
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  axil_req_t i_axil,
  output axil_rsp_t o_axil,
  output logic      o_bus_valid,
  output bus_req_t  o_bus_req,
  input  logic      i_bus_ready,
  input  bus_rsp_t  i_bus_rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS_BUSY,
    ST_RESP_WAIT
  } state_e;

  localparam int STRB_W = DATA_W / 8;

  state_e            state;
  logic              write_sel;
  logic              read_sel;
  logic              req_valid;
  logic              bus_done;
  logic              rsp_taken;
  bus_req_t          live_req;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  resp_t             resp_q;

  // fixed priority between the write pair and the read address
  always_comb begin
    if (WRITE_FIRST) begin
      write_sel = i_axil.awvalid && i_axil.wvalid;
      read_sel  = i_axil.arvalid && !i_axil.wvalid;
    end else begin
      read_sel  = i_axil.arvalid;
      write_sel = i_axil.awvalid && i_axil.wvalid && !i_axil.arvalid;
    end
  end

  assign req_valid = (state == ST_IDLE) && (write_sel || read_sel);

  always_comb begin
    live_req.address    = write_sel ? i_axil.awaddr : i_axil.araddr;
    live_req.write      = write_sel;
    live_req.write_data = i_axil.wdata;
    live_req.strobe     = i_axil.wstrb;
  end

  // in idle the request goes straight out, later the held copy does
  assign o_bus_valid = req_valid || (state == ST_BUS_BUSY);

  always_comb begin
    if (state == ST_IDLE) begin
      o_bus_req = live_req;
    end else begin
      o_bus_req.address    = addr_q;
      o_bus_req.write      = write_q;
      o_bus_req.write_data = wdata_q;
      o_bus_req.strobe     = strb_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_valid) begin
      addr_q  <= live_req.address;
      write_q <= live_req.write;
      wdata_q <= live_req.write_data;
      strb_q  <= live_req.strobe;
    end
  end

  assign bus_done  = o_bus_valid && i_bus_ready;
  assign rsp_taken = (bvalid_q && i_axil.bready) || (rvalid_q && i_axil.rready);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else if (rsp_taken) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else if (bus_done) begin
      bvalid_q <= o_bus_req.write;
      rvalid_q <= !o_bus_req.write;
    end
  end

  always_ff @(posedge i_clk) begin
    if (bus_done) begin
      resp_q  <= i_bus_rsp.status;
      rdata_q <= i_bus_rsp.read_data;
    end
  end

  always_comb begin
    o_axil.awready = write_sel && (state == ST_IDLE); // aw and w accepted together
    o_axil.wready  = write_sel && (state == ST_IDLE);
    o_axil.arready = read_sel && (state == ST_IDLE);
    o_axil.bvalid  = bvalid_q;
    o_axil.bresp   = resp_q;
    o_axil.rvalid  = rvalid_q;
    o_axil.rdata   = rdata_q;
    o_axil.rresp   = resp_q;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            state <= i_bus_ready ? ST_RESP_WAIT : ST_BUS_BUSY;
          end
        end
        ST_BUS_BUSY: begin
          if (i_bus_ready) begin
            state <= ST_RESP_WAIT;
          end
        end
        ST_RESP_WAIT: begin
          if (rsp_taken) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: design/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder
  import regblk_pkg::*;
#(
  parameter int ADDR_W   = regblk_pkg::ADDR_W,
  parameter int DATA_W   = regblk_pkg::DATA_W,
  parameter int NUM_REGS = regblk_pkg::NUM_REGS
) (
  input  logic                i_bus_valid,
  input  bus_req_t            i_bus_req,
  output logic                o_bus_ready,
  output bus_rsp_t            o_bus_rsp,
  output logic [NUM_REGS-1:0] o_wr_en,
  output logic [NUM_REGS-1:0] o_rd_en,
  output data_t               o_wdata,
  output strb_t               o_wstrb,
  input  data_t               i_rdata [NUM_REGS]
);

  // slot order here sets the index of each register's strobe and read data
  localparam addr_t REG_MAP [NUM_REGS] = '{REG_CTRL, REG_SCRATCH, REG_STATUS, REG_EVENT};

  logic [NUM_REGS-1:0] hit;
  logic                ro_hit;
  logic                err;
  logic [DATA_W-1:0]   rdata_sel;

  // byte offset within the word is ignored
  always_comb begin
    hit = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (i_bus_req.address[ADDR_W-1:2] == REG_MAP[i][ADDR_W-1:2]) begin
        hit[i] = 1'b1;
      end
    end
  end

  assign ro_hit = (i_bus_req.address[ADDR_W-1:2] == REG_STATUS[ADDR_W-1:2]);
  assign err    = (hit == '0) || (i_bus_req.write && ro_hit);

  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (hit[i]) begin
        rdata_sel = rdata_sel | i_rdata[i];
      end
    end
  end

  // every slot answers in the same cycle
  assign o_bus_ready = i_bus_valid;

  assign o_wr_en = (i_bus_valid && i_bus_req.write && !err) ? hit : '0;
  assign o_rd_en = (i_bus_valid && !i_bus_req.write && !err) ? hit : '0;
  assign o_wdata = i_bus_req.write_data;
  assign o_wstrb = i_bus_req.strobe;

  always_comb begin
    o_bus_rsp.read_data = err ? '0 : rdata_sel;
    o_bus_rsp.status    = err ? RESP_SLVERR : RESP_OKAY;
  end

endmodule

// File: design/event_flag_register.sv
`timescale 1ns/10ps

module event_flag_register #(
  parameter int DATA_W = 32
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [DATA_W-1:0]     i_event,
  input  logic                  i_wr_en,
  input  logic [DATA_W-1:0]     i_wdata,
  input  logic [DATA_W/8-1:0]   i_wstrb,
  output logic [DATA_W-1:0]     o_flags
);

  localparam int LANES = DATA_W / 8;

  logic [DATA_W-1:0] flags_q;
  logic [DATA_W-1:0] lane_mask;
  logic [DATA_W-1:0] clr;

  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      lane_mask[b*8 +: 8] = {8{i_wstrb[b]}};
    end
  end

  // write one to clear, only in enabled lanes
  assign clr = i_wr_en ? (i_wdata & lane_mask) : '0;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q & ~clr) | i_event;  // a pulse beats a clear in the same cycle
    end
  end

  assign o_flags = flags_q;

endmodule

// File: design/regblk_pkg.sv
package regblk_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;   // byte address
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;   // one bit per byte lane
  typedef logic [1:0]          resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // master to slave
  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } axil_rsp_t;

  typedef struct packed {
    addr_t address;
    logic  write;
    data_t write_data;
    strb_t strobe;
  } bus_req_t;

  typedef struct packed {
    data_t read_data;
    resp_t status;
  } bus_rsp_t;

  localparam addr_t REG_CTRL    = 8'h00;
  localparam addr_t REG_SCRATCH = 8'h04;
  localparam addr_t REG_STATUS  = 8'h08;   // read only
  localparam addr_t REG_EVENT   = 8'h0C;

  localparam int    NUM_REGS    = 4;
  localparam data_t CTRL_RESET  = 32'h0000_0001;

endpackage

// File: design/regblk_top.sv
`timescale 1ns/10ps

module regblk_top
  import regblk_pkg::*;
#(
  parameter int ADDR_W      = regblk_pkg::ADDR_W,
  parameter int DATA_W      = regblk_pkg::DATA_W,
  parameter bit WRITE_FIRST = 1'b1
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  axil_req_t i_axil,
  output axil_rsp_t o_axil,
  input  data_t     i_status,
  input  data_t     i_event,
  output data_t     o_ctrl,
  output data_t     o_event_flags
);

  logic                bus_valid;
  logic                bus_ready;
  bus_req_t            bus_req;
  bus_rsp_t            bus_rsp;
  logic [NUM_REGS-1:0] wr_en;
  data_t               wdata;
  strb_t               wstrb;
  data_t               scratch_value;
  data_t               rdata [NUM_REGS];

  // same slot order as the decoder's map
  assign rdata = '{o_ctrl, scratch_value, i_status, o_event_flags};

  axil_adapter #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .WRITE_FIRST (WRITE_FIRST)
  ) u_adapter (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_axil      (i_axil),
    .o_axil      (o_axil),
    .o_bus_valid (bus_valid),
    .o_bus_req   (bus_req),
    .i_bus_ready (bus_ready),
    .i_bus_rsp   (bus_rsp)
  );

  bus_decoder #(
    .ADDR_W   (ADDR_W),
    .DATA_W   (DATA_W),
    .NUM_REGS (NUM_REGS)
  ) u_decoder (
    .i_bus_valid (bus_valid),
    .i_bus_req   (bus_req),
    .o_bus_ready (bus_ready),
    .o_bus_rsp   (bus_rsp),
    .o_wr_en     (wr_en),
    .o_rd_en     (),  // no register here has read side effects
    .o_wdata     (wdata),
    .o_wstrb     (wstrb),
    .i_rdata     (rdata)
  );

  rw_register #(
    .DATA_W      (DATA_W),
    .RESET_VALUE (CTRL_RESET)
  ) u_ctrl (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wr_en (wr_en[0]),
    .i_wdata (wdata),
    .i_wstrb (wstrb),
    .o_value (o_ctrl)
  );

  rw_register #(
    .DATA_W      (DATA_W),
    .RESET_VALUE ('0)
  ) u_scratch (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wr_en (wr_en[1]),
    .i_wdata (wdata),
    .i_wstrb (wstrb),
    .o_value (scratch_value)
  );

  // slot 2 is the read-only status word, so wr_en[2] never rises
  event_flag_register #(
    .DATA_W (DATA_W)
  ) u_event (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_event (i_event),
    .i_wr_en (wr_en[3]),
    .i_wdata (wdata),
    .i_wstrb (wstrb),
    .o_flags (o_event_flags)
  );

endmodule

// File: design/rw_register.sv
`timescale 1ns/10ps

module rw_register #(
  parameter int                DATA_W      = 32,
  parameter logic [DATA_W-1:0] RESET_VALUE = '0
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_wr_en,
  input  logic [DATA_W-1:0]     i_wdata,
  input  logic [DATA_W/8-1:0]   i_wstrb,
  output logic [DATA_W-1:0]     o_value
);

  localparam int LANES = DATA_W / 8;

  logic [DATA_W-1:0] value_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      value_q <= RESET_VALUE;
    end else if (i_wr_en) begin
      for (int b = 0; b < LANES; b++) begin
        if (i_wstrb[b]) begin
          value_q[b*8 +: 8] <= i_wdata[b*8 +: 8]; // lanes without strobe keep their byte
        end
      end
    end
  end

  assign o_value = value_q;

endmodule

// File: dv/tb_regblk.sv
`timescale 1ns/10ps

module tb_regblk
  import regblk_pkg::*;
;

  localparam int NUM_XFERS = 76;
  localparam int WATCHDOG_CYCLES = NUM_XFERS * 40 + 200;

  logic      clk;
  logic      rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  data_t     status_word;
  data_t     event_pulse;
  data_t     ctrl_out;
  data_t     flags_out;

  integer seed;
  int     errors;
  int     checks;

  // expected register contents
  data_t  exp_ctrl;
  data_t  exp_scratch;
  data_t  exp_flags;

  // write that the DUT accepts on the coming rising edge
  logic   hs_wr;
  addr_t  hs_addr;
  data_t  hs_data;
  strb_t  hs_strb;

  regblk_top #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .WRITE_FIRST (1'b1)
  ) i_dut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_axil        (axil_req),
    .o_axil        (axil_rsp),
    .i_status      (status_word),
    .i_event       (event_pulse),
    .o_ctrl        (ctrl_out),
    .o_event_flags (flags_out)
  );

  always #4 clk = ~clk;

  task automatic report_error(input string what);
    errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  task automatic compare_value(input string name, input addr_t addr, input data_t got,
                               input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s (addr 0x%h): got 0x%h expected 0x%h", name, addr, got, exp);
    end
  endtask

  function automatic data_t lane_mask(input strb_t strb);
    data_t mask;
    for (int b = 0; b < DATA_W / 8; b++) begin
      mask[8*b +: 8] = strb[b] ? 8'hFF : 8'h00;
    end
    return mask;
  endfunction

  function automatic data_t merge_lanes(input data_t old, input data_t val, input strb_t strb);
    return (old & ~lane_mask(strb)) | (val & lane_mask(strb));
  endfunction

  function automatic resp_t model_resp(input addr_t addr, input logic write);
    logic [5:0] word;
    word = addr[7:2];
    if (write && word == REG_STATUS[7:2]) begin
      return RESP_SLVERR;  // status word is read only
    end
    if (word == REG_CTRL[7:2] || word == REG_SCRATCH[7:2] || word == REG_STATUS[7:2] ||
        word == REG_EVENT[7:2]) begin
      return RESP_OKAY;
    end
    return RESP_SLVERR;
  endfunction

  function automatic data_t model_read(input addr_t addr);
    case (addr[7:2])
      REG_CTRL[7:2]:    return exp_ctrl;
      REG_SCRATCH[7:2]: return exp_scratch;
      REG_STATUS[7:2]:  return status_word;
      REG_EVENT[7:2]:   return exp_flags;
      default:          return '0;
    endcase
  endfunction

  // reference model, updated on the same edges as the registers
  always @(posedge clk or negedge rst_n) begin
    data_t clr;
    if (!rst_n) begin
      exp_ctrl    = CTRL_RESET;
      exp_scratch = '0;
      exp_flags   = '0;
    end else begin
      clr = '0;
      if (hs_wr && model_resp(hs_addr, 1'b1) == RESP_OKAY) begin
        case (hs_addr[7:2])
          REG_CTRL[7:2]:    exp_ctrl = merge_lanes(exp_ctrl, hs_data, hs_strb);
          REG_SCRATCH[7:2]: exp_scratch = merge_lanes(exp_scratch, hs_data, hs_strb);
          REG_EVENT[7:2]:   clr = hs_data & lane_mask(hs_strb);
          default:          clr = '0;
        endcase
      end
      exp_flags = (exp_flags & ~clr) | event_pulse;  // set beats clear
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      compare_value("o_ctrl", REG_CTRL, ctrl_out, exp_ctrl);
      compare_value("o_event_flags", REG_EVENT, flags_out, exp_flags);
    end
  end

  a_write_latency: assert property (@(posedge clk) disable iff (!rst_n)
    axil_req.awvalid && axil_rsp.awready |=> axil_rsp.bvalid)
    else report_error("bvalid did not rise one cycle after the write handshake");
  a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    axil_req.arvalid && axil_rsp.arready |=> axil_rsp.rvalid)
    else report_error("rvalid did not rise one cycle after the read handshake");
  a_b_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(axil_rsp.bvalid) |-> $past(axil_req.awvalid && axil_rsp.awready))
    else report_error("bvalid rose without a write handshake in the cycle before");
  a_r_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(axil_rsp.rvalid) |-> $past(axil_req.arvalid && axil_rsp.arready))
    else report_error("rvalid rose without a read handshake in the cycle before");
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else report_error("write response dropped or changed before bready");
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else report_error("read response dropped or changed before rready");
  a_quiet_ready: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid || axil_rsp.rvalid |->
      !(axil_rsp.awready || axil_rsp.wready || axil_rsp.arready))
    else report_error("a ready was raised while a response was pending");
  a_aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.awready == axil_rsp.wready)
    else report_error("awready and wready were not raised together");

  task automatic note_write(input addr_t addr, input data_t data, input strb_t strb);
    hs_wr   = 1'b1;
    hs_addr = addr;
    hs_data = data;
    hs_strb = strb;
  endtask

  // pulse is driven on i_event while the write waits, so it meets the clear
  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           input data_t pulse);
    int stall;
    stall = $unsigned($random(seed)) % 6;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    event_pulse      <= pulse;
    do @(negedge clk); while (!axil_rsp.awready);
    note_write(addr, data, strb);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    event_pulse      <= '0;
    hs_wr            <= 1'b0;
    do @(negedge clk); while (!axil_rsp.bvalid);
    repeat (stall) @(negedge clk);  // back-pressure on B
    compare_value("bresp", addr, data_t'(axil_rsp.bresp), data_t'(model_resp(addr, 1'b1)));
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input addr_t addr);
    int    stall;
    data_t exp_data;
    resp_t exp_rsp;
    stall = $unsigned($random(seed)) % 6;
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    do @(negedge clk); while (!axil_rsp.arready);
    exp_data = model_read(addr);
    exp_rsp  = model_resp(addr, 1'b0);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    do @(negedge clk); while (!axil_rsp.rvalid);
    repeat (stall) @(negedge clk);
    compare_value("rdata", addr, axil_rsp.rdata, exp_data);
    compare_value("rresp", addr, data_t'(axil_rsp.rresp), data_t'(exp_rsp));
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  // write and read offered in the same cycle, the write has priority
  task automatic write_read_pair(input addr_t addr, input data_t data);
    int stall;
    stall = $unsigned($random(seed)) % 6;
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= '1;
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.bready  <= 1'b0;
    axil_req.rready  <= 1'b1;
    @(negedge clk);
    assert (axil_rsp.awready && !axil_rsp.arready)
      else report_error("the read was accepted ahead of the pending write");
    note_write(addr, data, '1);
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    hs_wr            <= 1'b0;
    do @(negedge clk); while (!(axil_rsp.bvalid || axil_rsp.rvalid));
    assert (axil_rsp.bvalid && !axil_rsp.rvalid)
      else report_error("the read response came before the write response");
    repeat (stall) @(negedge clk);  // the read stays offered while B is held
    @(posedge clk);
    axil_req.bready <= 1'b1;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    axil_req.bready  <= 1'b0;
    do @(negedge clk); while (!axil_rsp.rvalid);
    compare_value("rdata", addr, axil_rsp.rdata, data);
    compare_value("rresp", addr, data_t'(axil_rsp.rresp), data_t'(RESP_OKAY));
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic pulse_events(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      event_pulse <= $random(seed);
    end
    @(posedge clk);
    event_pulse <= '0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed        = 26790;
    errors      = 0;
    checks      = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    axil_req    = '0;
    status_word = '0;
    event_pulse = '0;
    hs_wr       = 1'b0;
    hs_addr     = '0;
    hs_data     = '0;
    hs_strb     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    assert (!(axil_rsp.awready || axil_rsp.wready || axil_rsp.arready ||
              axil_rsp.bvalid || axil_rsp.rvalid))
      else report_error("AXI ready or valid outputs were high after reset");
    compare_value("o_ctrl", REG_CTRL, ctrl_out, CTRL_RESET);
    axi_read(REG_SCRATCH);
    axi_read(REG_EVENT);

    repeat (12) begin
      axi_write(REG_CTRL, $random(seed), strb_t'($random(seed)), '0);
      axi_write(REG_SCRATCH, $random(seed), strb_t'($random(seed)), '0);
      axi_read(REG_CTRL);
      axi_read(REG_SCRATCH);
    end

    // error responses leave every register as it was
    @(posedge clk);
    status_word <= $random(seed);
    axi_read(REG_STATUS);
    axi_write(REG_STATUS, $random(seed), '1, '0);
    axi_read(8'h10);
    axi_write(8'h10, $random(seed), '1, '0);
    axi_write(8'hFC, $random(seed), '1, '0);
    axi_read(REG_SCRATCH);

    repeat (6) begin
      pulse_events(4);
      axi_read(REG_EVENT);
      axi_write(REG_EVENT, $random(seed), strb_t'($random(seed)), $random(seed));
      axi_read(REG_EVENT);
    end

    write_read_pair(REG_SCRATCH, $random(seed));
    repeat (4) @(posedge clk);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/regblk_pkg.sv
design/axil_adapter.sv
design/bus_decoder.sv
design/rw_register.sv
design/event_flag_register.sv
design/regblk_top.sv
dv/tb_regblk.sv
